/* src/mem_params.svh */
// Memory subsystem parameters
// Depth, address width and reset PC shared by the design and testbench

`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// ======================================================================
// Memory geometry
// ======================================================================

// Number of 32-bit words in the shared memory
`define MEM_WORDS 1024

// Byte address width on both ports
`define MEM_ADDR_W 32

// ======================================================================
// Fetch
// ======================================================================

// Byte address loaded into the PC during reset
`define MEM_RESET_PC 32'h0000_0000

`endif

/* src/mem_pkg.sv */
// Memory subsystem types
// Addresses, data words, load/store kinds and the port structs

`include "mem_params.svh"

package mem_pkg;

    // Basic widths
    typedef logic [`MEM_ADDR_W-1:0] addr_t;
    typedef logic [31:0]            word_t;

    // Word index, byte address without the two offset bits
    typedef logic [`MEM_ADDR_W-3:0] word_idx_t;

    // Load/store kinds
    // Bit 3 marks a store, bit 2 an unsigned load, bits 1:0 the size
    typedef enum logic [3:0] {
        OP_LB  = 4'b0000,
        OP_LH  = 4'b0001,
        OP_LW  = 4'b0010,
        OP_LBU = 4'b0100,
        OP_LHU = 4'b0101,
        OP_SB  = 4'b1000,
        OP_SH  = 4'b1001,
        OP_SW  = 4'b1010
    } mem_op_e;

    // One memory word seen as byte lanes or as halfword lanes
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
    } mem_word_u;

    // Load/store request from the core side
    typedef struct packed {
        logic    valid;
        mem_op_e op;
        addr_t   addr;
        word_t   wdata;
    } data_req_t;

    // Load/store response
    typedef struct packed {
        logic  valid;
        word_t rdata;
        logic  error;
    } data_rsp_t;

    // Fetch response
    typedef struct packed {
        logic  valid;
        addr_t pc;
        word_t instr;
        logic  error;
    } fetch_rsp_t;

    // PC redirect from the core
    typedef struct packed {
        logic  valid;
        addr_t target;
    } redirect_t;

    // Word access between the aligner and the memory
    typedef struct packed {
        logic       valid;
        logic       write;
        word_idx_t  idx;
        logic [3:0] strb;
        word_t      wdata;
    } word_req_t;

endpackage

/* src/mem_array.sv */
// Shared word memory
// Combinational instruction and data reads, byte-strobed writes,
// range errors on both ports

`include "mem_params.svh"

module mem_array import mem_pkg::*; (
    input  logic      clk_i,

    // Instruction port
    input  logic      ifetch_valid_i,
    input  addr_t     ifetch_addr_i,
    output word_t     ifetch_data_o,
    output logic      ifetch_err_o,

    // Data port
    input  word_req_t word_req_i,
    output word_t     word_rdata_o,
    output logic      word_err_o
);

    // Bits needed to address the array itself
    localparam int IDX_W = $clog2(`MEM_WORDS);

    // Storage, contents undefined until written
    word_t mem_q [`MEM_WORDS];

    word_idx_t if_idx;
    logic      if_in_range;
    logic      d_in_range;

    // ==================================================================
    // Instruction port
    // ==================================================================

    assign if_idx      = ifetch_addr_i[`MEM_ADDR_W-1:2];
    assign if_in_range = (if_idx < `MEM_WORDS);

    // Zero data outside the array
    assign ifetch_data_o = (ifetch_valid_i && if_in_range) ?
                           mem_q[if_idx[IDX_W-1:0]] : '0;
    assign ifetch_err_o  = ifetch_valid_i && !if_in_range;

    // ==================================================================
    // Data port
    // ==================================================================

    assign d_in_range = (word_req_i.idx < `MEM_WORDS);

    // Read data is the whole word, the aligner picks the lane
    assign word_rdata_o = (word_req_i.valid && d_in_range) ?
                          mem_q[word_req_i.idx[IDX_W-1:0]] : '0;
    assign word_err_o   = word_req_i.valid && !d_in_range;

    // Byte lanes written at the edge ending the request cycle
    // Out of range index writes nothing
    always_ff @(posedge clk_i) begin
        if (word_req_i.valid && word_req_i.write && d_in_range) begin
            for (int i = 0; i < 4; i++) begin
                if (word_req_i.strb[i]) begin
                    mem_q[word_req_i.idx[IDX_W-1:0]][i*8 +: 8] <=
                        word_req_i.wdata[i*8 +: 8];
                end
            end
        end
    end

endmodule

/* src/lsu_align.sv */
// Load/store aligner
// Turns byte, halfword and word operations into word accesses with
// strobes, and extends load data back into a register value

`include "mem_params.svh"

module lsu_align import mem_pkg::*; (
    input  data_req_t data_req_i,
    output word_req_t word_req_o,
    input  word_t     word_rdata_i,
    input  logic      word_err_i,
    output data_rsp_t data_rsp_o
);

    // Access size codes
    localparam logic [1:0] SZ_BYTE = 2'd0;
    localparam logic [1:0] SZ_HALF = 2'd1;
    localparam logic [1:0] SZ_WORD = 2'd2;

    logic [1:0] size;
    logic       is_store;
    logic       is_unsigned;
    logic       op_bad;
    logic [1:0] lane;
    logic       misaligned;
    logic       local_err;
    logic       rsp_err;
    logic [3:0] strb;
    mem_word_u  st_word;
    mem_word_u  ld_word;
    word_t      ld_ext;

    // ==================================================================
    // Operation decode
    // ==================================================================

    always_comb begin
        size        = SZ_WORD;
        is_store    = 1'b0;
        is_unsigned = 1'b0;
        op_bad      = 1'b0;
        case (data_req_i.op)
            OP_LB:  size = SZ_BYTE;
            OP_LH:  size = SZ_HALF;
            OP_LW:  size = SZ_WORD;
            OP_LBU: begin
                size        = SZ_BYTE;
                is_unsigned = 1'b1;
            end
            OP_LHU: begin
                size        = SZ_HALF;
                is_unsigned = 1'b1;
            end
            OP_SB: begin
                size     = SZ_BYTE;
                is_store = 1'b1;
            end
            OP_SH: begin
                size     = SZ_HALF;
                is_store = 1'b1;
            end
            OP_SW: begin
                size     = SZ_WORD;
                is_store = 1'b1;
            end
            // Unused encodings are treated as failed loads
            default: op_bad = 1'b1;
        endcase
    end

    // Byte offset inside the word
    assign lane = data_req_i.addr[1:0];

    // Halfwords need an even address, words a multiple of 4
    always_comb begin
        case (size)
            SZ_HALF: misaligned = lane[0];
            SZ_WORD: misaligned = |lane;
            default: misaligned = 1'b0;
        endcase
    end

    assign local_err = misaligned | op_bad;

    // ==================================================================
    // Store lane placement
    // ==================================================================

    always_comb begin
        st_word = '0;
        strb    = 4'b0000;
        case (size)
            SZ_BYTE: begin
                st_word.b[lane] = data_req_i.wdata[7:0];
                strb[lane]      = 1'b1;
            end
            SZ_HALF: begin
                st_word.h[lane[1]] = data_req_i.wdata[15:0];
                strb               = lane[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                st_word = data_req_i.wdata;
                strb    = 4'b1111;
            end
        endcase
    end

    // Word request, failed stores drop the write
    always_comb begin
        word_req_o.valid = data_req_i.valid;
        word_req_o.write = is_store && !local_err;
        word_req_o.idx   = data_req_i.addr[`MEM_ADDR_W-1:2];
        word_req_o.strb  = strb;
        word_req_o.wdata = st_word;
    end

    // ==================================================================
    // Load extraction and response
    // ==================================================================

    assign ld_word = word_rdata_i;

    // Pick the addressed lane, then sign or zero extend
    always_comb begin
        case (size)
            SZ_BYTE: ld_ext = is_unsigned ? {24'b0, ld_word.b[lane]} :
                                            {{24{ld_word.b[lane][7]}}, ld_word.b[lane]};
            SZ_HALF: ld_ext = is_unsigned ? {16'b0, ld_word.h[lane[1]]} :
                                            {{16{ld_word.h[lane[1]][15]}}, ld_word.h[lane[1]]};
            default: ld_ext = ld_word;
        endcase
    end

    // Range error from memory joins the local checks
    assign rsp_err = data_req_i.valid && (local_err || word_err_i);

    // Stores and failed accesses return zero data
    always_comb begin
        data_rsp_o.valid = data_req_i.valid;
        data_rsp_o.error = rsp_err;
        data_rsp_o.rdata = (data_req_i.valid && !is_store && !rsp_err) ? ld_ext : '0;
    end

endmodule

/* src/fetch_unit.sv */
// Instruction fetch unit
// Program counter with reset value, sequential step and redirect,
// driving the instruction port of the memory

`include "mem_params.svh"

module fetch_unit import mem_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       fetch_en_i,
    input  redirect_t  redirect_i,
    output logic       ifetch_valid_o,
    output addr_t      ifetch_addr_o,
    input  word_t      ifetch_data_i,
    input  logic       ifetch_err_i,
    output fetch_rsp_t fetch_o
);

    addr_t pc_q;
    logic  active_q;
    logic  fetch_go;
    logic  pc_misaligned;
    logic  fetch_err;

    // Low through reset, keeps fetches off until reset is released
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            active_q <= 1'b0;
        end else begin
            active_q <= 1'b1;
        end
    end

    assign fetch_go = fetch_en_i && active_q;

    // Redirect wins over the sequential step
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q <= `MEM_RESET_PC;
        end else if (redirect_i.valid) begin
            pc_q <= redirect_i.target;
        end else if (fetch_go) begin
            pc_q <= pc_q + addr_t'(4);
        end
    end

    // Instruction port request
    assign ifetch_valid_o = fetch_go;
    assign ifetch_addr_o  = pc_q;

    // Misaligned PC joins the memory range error
    assign pc_misaligned = |pc_q[1:0];
    assign fetch_err     = fetch_go && (pc_misaligned || ifetch_err_i);

    always_comb begin
        fetch_o.valid = fetch_go;
        fetch_o.pc    = pc_q;
        fetch_o.instr = fetch_err ? '0 : ifetch_data_i;
        fetch_o.error = fetch_err;
    end

endmodule

/* src/mem_subsys_top.sv */
// Memory subsystem top level
// Fetch unit and load/store aligner sharing one word memory

module mem_subsys_top import mem_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,

    // Fetch control
    input  logic       fetch_en_i,
    input  redirect_t  redirect_i,

    // Load/store request
    input  data_req_t  data_req_i,

    // Responses
    output fetch_rsp_t fetch_o,
    output data_rsp_t  data_rsp_o
);

    // Instruction port
    logic      ifetch_valid;
    addr_t     ifetch_addr;
    word_t     ifetch_data;
    logic      ifetch_err;

    // Data port
    word_req_t word_req;
    word_t     word_rdata;
    logic      word_err;

    // ==================================================================
    // Fetch side
    // ==================================================================

    fetch_unit u_fetch_unit (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .fetch_en_i     (fetch_en_i),
        .redirect_i     (redirect_i),
        .ifetch_valid_o (ifetch_valid),
        .ifetch_addr_o  (ifetch_addr),
        .ifetch_data_i  (ifetch_data),
        .ifetch_err_i   (ifetch_err),
        .fetch_o        (fetch_o)
    );

    // ==================================================================
    // Load/store side
    // ==================================================================

    lsu_align u_lsu_align (
        .data_req_i   (data_req_i),
        .word_req_o   (word_req),
        .word_rdata_i (word_rdata),
        .word_err_i   (word_err),
        .data_rsp_o   (data_rsp_o)
    );

    // Shared memory
    mem_array u_mem_array (
        .clk_i          (clk_i),
        .ifetch_valid_i (ifetch_valid),
        .ifetch_addr_i  (ifetch_addr),
        .ifetch_data_o  (ifetch_data),
        .ifetch_err_o   (ifetch_err),
        .word_req_i     (word_req),
        .word_rdata_o   (word_rdata),
        .word_err_o     (word_err)
    );

endmodule

/* testbench/tb_mem_model.svh */
// Reference model for the memory subsystem testbench
// Byte-accurate image of the first 64 words, load extension and PC tracking

`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

// Image of the test window, word i covers bytes 4i to 4i+3
mem_word_u img [64];

// PC the fetch unit should show in the current cycle
addr_t model_pc;

// Set once every window word holds a known value
bit image_loaded;

function automatic bit is_store_op(input mem_op_e op);
    return op inside {OP_SB, OP_SH, OP_SW};
endfunction

// Misaligned halfword or word, or beyond the end of memory
function automatic bit model_err(input mem_op_e op, input addr_t addr);
    bit mis;
    mis = 1'b0;
    if (op inside {OP_LH, OP_LHU, OP_SH})
        mis = addr[0];
    else if (op inside {OP_LW, OP_SW})
        mis = |addr[1:0];
    return mis || (addr >= `MEM_WORDS * 4);
endfunction

// Only lanes named by the store size change
function automatic void model_store(input mem_op_e op, input addr_t addr, input word_t wdata);
    case (op)
        OP_SB:   img[addr[7:2]].b[addr[1:0]] = wdata[7:0];
        OP_SH:   img[addr[7:2]].h[addr[1]] = wdata[15:0];
        OP_SW:   img[addr[7:2]] = wdata;
        default: ;
    endcase
endfunction

// Lane pick, then sign or zero extension
function automatic word_t model_load(input mem_op_e op, input addr_t addr);
    mem_word_u w;
    logic [7:0]  b;
    logic [15:0] h;
    w = img[addr[7:2]];
    b = w.b[addr[1:0]];
    h = w.h[addr[1]];
    case (op)
        OP_LB:   return {{24{b[7]}}, b};
        OP_LBU:  return {24'h0, b};
        OP_LH:   return {{16{h[15]}}, h};
        OP_LHU:  return {16'h0, h};
        default: return w;
    endcase
endfunction

`endif

/* testbench/tb_mem_subsys.sv */
// Memory subsystem testbench
// Fixed-seed random loads, stores and fetches checked against a model

`include "mem_params.svh"

module tb_mem_subsys import mem_pkg::*; ();

    // Reset, idle, fill, readback, mixed, errors, fetch, bad redirects, margin
    localparam int CYCLE_LIMIT = 5 + 3 + 128 + 400 + 64 + 200 + 16 + 100;

    logic       clk_i;
    logic       rst_i;
    logic       fetch_en_i;
    redirect_t  redirect_i;
    data_req_t  data_req_i;
    fetch_rsp_t fetch_o;
    data_rsp_t  data_rsp_o;

    integer     seed;
    int         cycles = 0;
    mem_op_e    op_list [8] = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW};
    redirect_t  no_rd;
    data_req_t  no_req;

    `include "tb_mem_model.svh"

    mem_subsys_top DUT (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .fetch_en_i (fetch_en_i),
        .redirect_i (redirect_i),
        .data_req_i (data_req_i),
        .fetch_o    (fetch_o),
        .data_rsp_o (data_rsp_o)
    );

    always #10 clk_i = ~clk_i;

    // Run limit
    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic check_val(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
        if (actual !== expected) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic data_req_t make_req(input mem_op_e op, input addr_t addr,
                                           input word_t wdata);
        data_req_t r;
        r.valid = 1'b1;
        r.op    = op;
        r.addr  = addr;
        r.wdata = wdata;
        return r;
    endfunction

    // Aligned access of any kind inside the 64-word window
    function automatic data_req_t rand_access();
        mem_op_e op;
        addr_t   off;
        op = op_list[{$random(seed)} % 8];
        if (op inside {OP_LB, OP_LBU, OP_SB})
            off = {$random(seed)} % 4;
        else if (op inside {OP_LH, OP_LHU, OP_SH})
            off = 2 * ({$random(seed)} % 2);
        else
            off = 0;
        return make_req(op, ({$random(seed)} % 64) * 4 + off, $random(seed));
    endfunction

    // ==================================================================
    // One clock cycle: drive on the falling edge, check mid-phase,
    // then advance the model as the rising edge will
    // ==================================================================

    task automatic do_cycle(input logic en, input redirect_t rd, input data_req_t req);
        bit    ferr;
        bit    derr;
        word_t exp_rdata;
        @(negedge clk_i);
        fetch_en_i = en;
        redirect_i = rd;
        data_req_i = req;
        #5;
        check_val(fetch_o.valid, en, "fetch valid");
        if (en) begin
            ferr = (model_pc[1:0] != 2'b00) || (model_pc >= `MEM_WORDS * 4);
            check_val(fetch_o.pc, model_pc, "fetch pc");
            check_val(fetch_o.error, ferr, "fetch error");
            // Instruction word is unknown before the fill
            if (ferr)
                check_val(fetch_o.instr, 32'h0, "fetch instr on error");
            else if (image_loaded)
                check_val(fetch_o.instr, img[model_pc[7:2]], "fetch instr");
        end
        check_val(data_rsp_o.valid, req.valid, "data valid");
        if (req.valid) begin
            derr = model_err(req.op, req.addr);
            exp_rdata = (derr || is_store_op(req.op)) ? 32'h0 : model_load(req.op, req.addr);
            check_val(data_rsp_o.error, derr, "data error");
            check_val(data_rsp_o.rdata, exp_rdata, "data rdata");
            if (!derr && is_store_op(req.op))
                model_store(req.op, req.addr, req.wdata);
        end
        if (rd.valid)
            model_pc = rd.target;
        else if (en)
            model_pc = model_pc + 4;
    endtask

    // ==================================================================
    // Test sequence
    // ==================================================================

    initial begin
        data_req_t  req;
        redirect_t  rd;
        int         idx;
        int         kind;
        seed         = 32'h5817_483d;
        clk_i        = 1'b0;
        rst_i        = 1'b1;
        fetch_en_i   = 1'b1;
        redirect_i   = '0;
        data_req_i   = '0;
        no_rd        = '0;
        no_req       = '0;
        model_pc     = `MEM_RESET_PC;
        image_loaded = 1'b0;

        // Fetch enabled through reset, still no valid fetch
        for (int i = 0; i < 5; i++) begin
            @(negedge clk_i);
            check_val(fetch_o.valid, 1'b0, "fetch valid in reset");
            check_val(fetch_o.pc, `MEM_RESET_PC, "fetch pc in reset");
        end
        fetch_en_i = 1'b0;
        rst_i      = 1'b0;

        // Quiet outputs, then the first fetch at the reset PC
        do_cycle(1'b0, no_rd, no_req);
        do_cycle(1'b0, no_rd, no_req);
        do_cycle(1'b1, no_rd, no_req);

        // Fill the window, then read it back
        for (int i = 0; i < 64; i++)
            do_cycle(1'b0, no_rd, make_req(OP_SW, i * 4, $random(seed)));
        for (int i = 0; i < 64; i++)
            do_cycle(1'b0, no_rd, make_req(OP_LW, i * 4, 32'h0));
        image_loaded = 1'b1;

        // Mixed aligned traffic
        for (int i = 0; i < 400; i++)
            do_cycle(1'b0, no_rd, rand_access());

        // Misaligned and out of range, each followed by a word readback
        for (int i = 0; i < 32; i++) begin
            kind = {$random(seed)} % 3;
            idx  = {$random(seed)} % 64;
            case (kind)
                0: req = make_req(op_list[{$random(seed)} % 2 ? 1 : 6],
                                  idx * 4 + 1 + 2 * ({$random(seed)} % 2), $random(seed));
                1: req = make_req(op_list[{$random(seed)} % 2 ? 2 : 7],
                                  idx * 4 + 1 + {$random(seed)} % 3, $random(seed));
                // Low index bits alias onto the window word read back next
                default: req = make_req(op_list[{$random(seed)} % 8],
                                        ($random(seed) & 32'hFFFF_F0FF) | 32'h1000,
                                        $random(seed));
            endcase
            do_cycle(1'b0, no_rd, req);
            do_cycle(1'b0, no_rd, make_req(OP_LW, {req.addr[7:2], 2'b00}, 32'h0));
        end

        // Fetch with redirects, PC kept inside the window
        for (int i = 0; i < 200; i++) begin
            rd.valid  = (model_pc >= 252) || ({$random(seed)} % 8 == 0);
            rd.target = ({$random(seed)} % 64) * 4;
            req = rand_access();
            req.valid = {$random(seed)} % 2 != 0;
            do_cycle({$random(seed)} % 4 != 0, rd, req);
        end

        // Misaligned or out of range redirect target, then back to an aligned one
        for (int i = 0; i < 8; i++) begin
            rd.valid = 1'b1;
            if (i % 2 == 0)
                rd.target = ({$random(seed)} % 64) * 4 + 1 + {$random(seed)} % 3;
            else
                rd.target = ($random(seed) | 32'h1000) & 32'hFFFF_FFFC;
            do_cycle(1'b0, rd, no_req);
            rd.target = ({$random(seed)} % 64) * 4;
            do_cycle(1'b1, rd, no_req);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* mem_subsys_top.f */
+incdir+src
+incdir+testbench
src/mem_pkg.sv
src/mem_array.sv
src/lsu_align.sv
src/fetch_unit.sv
src/mem_subsys_top.sv
testbench/tb_mem_subsys.sv
